// File: verilog/event_logger_macros.svh
/*
 * shared widths of the event logger core
 * config word bit positions (field enables and run bit)
 * glitch filter counter width
 */
`ifndef EVENT_LOGGER_MACROS_SVH
`define EVENT_LOGGER_MACROS_SVH

`define EL_GPIO_N     10 // gpio bits seen by the logger
`define EL_TIME_W     32 // local time width
`define EL_WORD_W     16 // output record word
`define EL_DENOISE_W  8  // level must hold 2**8 cycles

`define EL_CONF_GPS   7  // enable bit, field is [6:4] = {inv, sel[1:0]}
`define EL_CONF_MSG   13 // enable bit, field is [12:8] = {inv, idx[3:0]}
`define EL_CONF_EN    21 // enable bit, run bit is [20]

`endif

// File: verilog/event_cfg_pkg.sv
/*
 * configuration field types
 * gps pin select codes, message disable index
 * decoded logger configuration struct
 */
`default_nettype none
`include "event_logger_macros.svh"

package event_cfg_pkg;

    localparam logic [1:0] GPS_SEL_PIN3 = 2'b01; // takes gpio[GPS_PIN_A]
    localparam logic [1:0] GPS_SEL_PIN5 = 2'b10; // takes gpio[GPS_PIN_B]
    localparam int         GPS_PIN_A    = 3;
    localparam int         GPS_PIN_B    = 5;
    localparam logic [3:0] MSG_IDX_OFF  = 4'hf;  // message channel off

    typedef struct packed {
        logic       inv; // invert pps pin
        logic [1:0] sel; // 00/11 off
    } gps_cfg_t;

    typedef struct packed {
        logic       inv; // invert trigger
        logic [3:0] idx; // gpio bit, >= EL_GPIO_N reads 0
    } msg_cfg_t;

    typedef struct packed {
        gps_cfg_t gps;
        msg_cfg_t msg;
        logic     hold;   // high keeps the logger idle and cleared
        logic     gps_en; // gps channel running
        logic     msg_en; // msg channel running
    } logger_cfg_t;

endpackage

`default_nettype wire

// File: verilog/event_rec_pkg.sv
/*
 * event payloads captured by the two channels
 * channel codes placed in record word 0
 * sample counter width and output word struct
 */
`default_nettype none
`include "event_logger_macros.svh"

package event_rec_pkg;

    typedef enum logic [3:0] {
        CHAN_GPS = 4'd1,
        CHAN_MSG = 4'd3
    } chan_code_t;

    // word 0 = {code, sample counter}
    localparam int SAMPLE_W = `EL_WORD_W - $bits(chan_code_t);

    typedef struct packed {
        logic [`EL_TIME_W-1:0] ts; // local time at the leading edge
    } gps_event_t;

    typedef struct packed {
        logic [`EL_TIME_W-1:0] ts;   // local time at the leading edge
        logic [`EL_GPIO_N-1:0] gpio; // gpio snapshot, same cycle
    } msg_event_t;

    typedef struct packed {
        logic                  stb;  // one of four consecutive words
        logic [`EL_WORD_W-1:0] data;
    } rec_word_t;

endpackage

`default_nettype wire

// File: verilog/event_cfg_regs.sv
/*
 * configuration register of the logger
 * per-field write enables, hold level from the run bit
 * gps and message channel enable decode
 */
`timescale 1ns/1ps
`default_nettype none
`include "event_logger_macros.svh"

module event_cfg_regs (
    input  wire                        i_xclk,
    input  wire                        i_config_rst,
    input  wire                        i_cfg_we, // one cycle write strobe
    input  wire [31:0]                 i_cfg_wd,
    output event_cfg_pkg::logger_cfg_t o_cfg
);
    import event_cfg_pkg::*;

    localparam int GPS_W = $bits(gps_cfg_t);
    localparam int MSG_W = $bits(msg_cfg_t);

    gps_cfg_t gps_r;
    msg_cfg_t msg_r;
    logic     hold_r; // inverse of the run bit

    always_ff @(posedge i_xclk) begin
        if (i_config_rst) begin
            gps_r  <= '0;                               // pps off
            msg_r  <= '{inv: 1'b0, idx: MSG_IDX_OFF};   // trigger off
            hold_r <= 1'b1;                             // idle until run written
        end else if (i_cfg_we) begin
            if (i_cfg_wd[`EL_CONF_GPS]) gps_r  <= gps_cfg_t'(i_cfg_wd[`EL_CONF_GPS-1 -: GPS_W]);
            if (i_cfg_wd[`EL_CONF_MSG]) msg_r  <= msg_cfg_t'(i_cfg_wd[`EL_CONF_MSG-1 -: MSG_W]);
            if (i_cfg_wd[`EL_CONF_EN])  hold_r <= ~i_cfg_wd[`EL_CONF_EN-1];
        end
    end

    assign o_cfg.gps    = gps_r;
    assign o_cfg.msg    = msg_r;
    assign o_cfg.hold   = hold_r;
    assign o_cfg.gps_en = (^gps_r.sel) && !hold_r;           // 00 and 11 disable
    assign o_cfg.msg_en = (msg_r.idx != MSG_IDX_OFF) && !hold_r;

endmodule

`default_nettype wire

// File: verilog/pulse_denoiser.sv
/*
 * 3-stage synchronizer for an asynchronous level
 * stable-level filter, input must hold 2**EL_DENOISE_W cycles
 * single-cycle pulse on the rising stable level
 */
`timescale 1ns/1ps
`default_nettype none
`include "event_logger_macros.svh"

module pulse_denoiser (
    input  wire  i_xclk,
    input  wire  i_config_rst,
    input  wire  i_clear,  // channel off or reconfigured
    input  wire  i_level,  // selected and inverted pin
    output logic o_pulse
);
    logic [2:0]               sync;     // [2] is the usable copy
    logic                     stable;   // filtered level
    logic                     stable_d; // for edge detect
    logic [`EL_DENOISE_W-1:0] cnt;      // cycles left before stable follows
    logic                     pulse_r;

    always_ff @(posedge i_xclk) begin
        if (i_config_rst) begin
            sync     <= '0;
            stable   <= 1'b0;
            stable_d <= 1'b0;
            cnt      <= '1;
            pulse_r  <= 1'b0;
        end else if (i_clear) begin
            // preload with the present level so a new idle level is no edge
            sync     <= {3{i_level}};
            stable   <= i_level;
            stable_d <= i_level;
            cnt      <= '1;
            pulse_r  <= 1'b0;
        end else begin
            sync     <= {sync[1:0], i_level};
            if (sync[2] == stable) cnt <= '1;          // unchanged, reload
            else                   cnt <= cnt - 1'b1;
            if (cnt == '0)         stable <= sync[2];  // full count of new level
            stable_d <= stable;
            pulse_r  <= stable && !stable_d;           // leading edge only
        end
    end

    assign o_pulse = pulse_r;

endmodule

`default_nettype wire

// File: verilog/event_slot.sv
/*
 * pending event holder, any payload type
 * captures on set, overwrites while pending
 * drops on acknowledge or clear
 */
`timescale 1ns/1ps
`default_nettype none

module event_slot #(
    parameter type payload_t = logic [31:0]
) (
    input  wire      i_xclk,
    input  wire      i_config_rst,
    input  wire      i_clear,    // channel off
    input  wire      i_set,      // leading edge pulse
    input  payload_t i_payload,
    input  wire      i_ack,      // taken by the arbiter
    output logic     o_valid,
    output payload_t o_payload
);
    always_ff @(posedge i_xclk) begin
        if (i_config_rst || i_clear) o_valid <= 1'b0;
        else if (i_set)              o_valid <= 1'b1; // new event beats the ack
        else if (i_ack)              o_valid <= 1'b0;
    end

    always_ff @(posedge i_xclk) begin
        if (i_set) o_payload <= i_payload; // arbiter copies it on ack
    end

endmodule

`default_nettype wire

// File: verilog/gps_pps_channel.sv
/*
 * gps pulse-per-second channel
 * pin select (gpio 3 or 5) and invert
 * glitch filter and time-only event slot
 */
`timescale 1ns/1ps
`default_nettype none
`include "event_logger_macros.svh"

module gps_pps_channel (
    input  wire                        i_xclk,
    input  wire                        i_config_rst,
    input  wire event_cfg_pkg::logger_cfg_t i_cfg,
    input  wire [`EL_GPIO_N-1:0]       i_gpio,
    input  wire [`EL_TIME_W-1:0]       i_time,
    input  wire                        i_ack,
    output logic                       o_valid,
    output event_rec_pkg::gps_event_t  o_event
);
    import event_cfg_pkg::*;
    import event_rec_pkg::*;

    gps_cfg_t   gps_q; // previous field, a change restarts the filter
    logic       pin;
    logic       level;
    logic       clear;
    logic       pulse;
    gps_event_t ev;

    always_comb begin
        case (i_cfg.gps.sel)
            GPS_SEL_PIN3: pin = i_gpio[GPS_PIN_A];
            GPS_SEL_PIN5: pin = i_gpio[GPS_PIN_B];
            default:      pin = 1'b0;             // channel off
        endcase
    end

    always_ff @(posedge i_xclk) begin
        if (i_config_rst) gps_q <= '0;
        else              gps_q <= i_cfg.gps;
    end

    assign level = i_cfg.gps.inv ^ pin;
    assign clear = !i_cfg.gps_en || (gps_q != i_cfg.gps); // off, held or rewritten
    assign ev.ts = i_time;

    pulse_denoiser pulse_denoiser_inst (
        .i_xclk       (i_xclk),
        .i_config_rst (i_config_rst),
        .i_clear      (clear),
        .i_level      (level),
        .o_pulse      (pulse)
    );

    event_slot #(
        .payload_t (gps_event_t)
    ) event_slot_inst (
        .i_xclk       (i_xclk),
        .i_config_rst (i_config_rst),
        .i_clear      (clear),
        .i_set        (pulse),
        .i_payload    (ev),
        .i_ack        (i_ack),
        .o_valid      (o_valid),
        .o_payload    (o_event)
    );

endmodule

`default_nettype wire

// File: verilog/ext_msg_channel.sv
/*
 * external message trigger channel
 * any gpio bit by index, with invert
 * glitch filter and time plus gpio snapshot slot
 */
`timescale 1ns/1ps
`default_nettype none
`include "event_logger_macros.svh"

module ext_msg_channel (
    input  wire                        i_xclk,
    input  wire                        i_config_rst,
    input  wire event_cfg_pkg::logger_cfg_t i_cfg,
    input  wire [`EL_GPIO_N-1:0]       i_gpio,
    input  wire [`EL_TIME_W-1:0]       i_time,
    input  wire                        i_ack,
    output logic                       o_valid,
    output event_rec_pkg::msg_event_t  o_event
);
    import event_cfg_pkg::*;
    import event_rec_pkg::*;

    localparam int IDX_N = 2 ** $bits(i_cfg.msg.idx); // 16 selectable bits

    msg_cfg_t         msg_q;    // previous field, a change restarts the filter
    logic [IDX_N-1:0] gpio_ext; // unused indexes read 0
    logic             level;
    logic             clear;
    logic             pulse;
    msg_event_t       ev;

    always_ff @(posedge i_xclk) begin
        if (i_config_rst) msg_q <= '{inv: 1'b0, idx: MSG_IDX_OFF};
        else              msg_q <= i_cfg.msg;
    end

    assign gpio_ext = {{(IDX_N-`EL_GPIO_N){1'b0}}, i_gpio};
    assign level    = i_cfg.msg.inv ^ gpio_ext[i_cfg.msg.idx];
    assign clear    = !i_cfg.msg_en || (msg_q != i_cfg.msg);
    assign ev.ts    = i_time;
    assign ev.gpio  = i_gpio; // snapshot taken with the time

    pulse_denoiser pulse_denoiser_inst (
        .i_xclk       (i_xclk),
        .i_config_rst (i_config_rst),
        .i_clear      (clear),
        .i_level      (level),
        .o_pulse      (pulse)
    );

    event_slot #(
        .payload_t (msg_event_t)
    ) event_slot_inst (
        .i_xclk       (i_xclk),
        .i_config_rst (i_config_rst),
        .i_clear      (clear),
        .i_set        (pulse),
        .i_payload    (ev),
        .i_ack        (i_ack),
        .o_valid      (o_valid),
        .o_payload    (o_event)
    );

endmodule

`default_nettype wire

// File: verilog/record_arbiter.sv
/*
 * fixed priority grant, gps over message
 * four-word record sequencer with payload latch
 * 12-bit sample counter, cleared while held
 */
`timescale 1ns/1ps
`default_nettype none
`include "event_logger_macros.svh"

module record_arbiter (
    input  wire                        i_xclk,
    input  wire                        i_config_rst,
    input  wire event_cfg_pkg::logger_cfg_t i_cfg,
    input  wire                        i_gps_valid,
    input  wire event_rec_pkg::gps_event_t  i_gps_event,
    input  wire                        i_msg_valid,
    input  wire event_rec_pkg::msg_event_t  i_msg_event,
    output logic                       o_gps_ack,
    output logic                       o_msg_ack,
    output event_rec_pkg::rec_word_t   o_rec
);
    import event_rec_pkg::*;

    logic                  busy;       // record words going out
    logic [1:0]            seq;        // word index
    logic [SAMPLE_W-1:0]   sample_cnt; // records since hold
    logic [`EL_WORD_W-1:0] word0;      // {code, counter} of this record
    logic [`EL_TIME_W-1:0] ts_l;
    logic [`EL_GPIO_N-1:0] snap_l;     // 0 for gps records
    logic                  take;
    logic [`EL_WORD_W-1:0] word_mux;

    assign take      = !busy && !i_cfg.hold && (i_gps_valid || i_msg_valid);
    assign o_gps_ack = take && i_gps_valid;
    assign o_msg_ack = take && !i_gps_valid; // msg only when gps idle

    always_ff @(posedge i_xclk) begin
        if (i_config_rst || i_cfg.hold) begin
            busy       <= 1'b0;
            seq        <= 2'd0;
            sample_cnt <= '0;
        end else if (take) begin
            busy       <= 1'b1;
            seq        <= 2'd0;
            sample_cnt <= sample_cnt + 1'b1;
        end else if (busy) begin
            seq <= seq + 2'd1;
            if (seq == 2'd3) busy <= 1'b0; // one idle cycle before the next grant
        end
    end

    always_ff @(posedge i_xclk) begin
        if (o_gps_ack) begin
            word0  <= {CHAN_GPS, sample_cnt};
            ts_l   <= i_gps_event.ts;
            snap_l <= '0;
        end else if (o_msg_ack) begin
            word0  <= {CHAN_MSG, sample_cnt};
            ts_l   <= i_msg_event.ts;
            snap_l <= i_msg_event.gpio;
        end
    end

    always_comb begin
        case (seq)
            2'd0:    word_mux = word0;
            2'd1:    word_mux = ts_l[`EL_WORD_W-1:0];               // time low
            2'd2:    word_mux = ts_l[`EL_TIME_W-1:`EL_WORD_W];      // time high
            default: word_mux = {{(`EL_WORD_W-`EL_GPIO_N){1'b0}}, snap_l};
        endcase
    end

    assign o_rec.stb  = busy && !i_cfg.hold; // silent while held
    assign o_rec.data = word_mux;

endmodule

`default_nettype wire

// File: verilog/event_logger_top.sv
/*
 * event logger core top level
 * config register, gps pps and message channels, record arbiter
 */
`timescale 1ns/1ps
`default_nettype none
`include "event_logger_macros.svh"

module event_logger_top (
    input  wire                      i_xclk,
    input  wire                      i_config_rst,
    input  wire                      i_cfg_we,
    input  wire [31:0]               i_cfg_wd,
    input  wire [`EL_GPIO_N-1:0]     i_gpio,
    input  wire [`EL_TIME_W-1:0]     i_time,
    output event_rec_pkg::rec_word_t o_rec
);
    import event_cfg_pkg::*;
    import event_rec_pkg::*;

    logger_cfg_t cfg;
    logic        gps_valid;
    logic        gps_ack;
    gps_event_t  gps_event;
    logic        msg_valid;
    logic        msg_ack;
    msg_event_t  msg_event;

    event_cfg_regs event_cfg_regs_inst (
        .i_xclk (i_xclk), .i_config_rst (i_config_rst),
        .i_cfg_we (i_cfg_we), .i_cfg_wd (i_cfg_wd), .o_cfg (cfg)
    );

    gps_pps_channel gps_pps_channel_inst (
        .i_xclk (i_xclk), .i_config_rst (i_config_rst), .i_cfg (cfg),
        .i_gpio (i_gpio), .i_time (i_time), .i_ack (gps_ack),
        .o_valid (gps_valid), .o_event (gps_event)
    );

    ext_msg_channel ext_msg_channel_inst (
        .i_xclk (i_xclk), .i_config_rst (i_config_rst), .i_cfg (cfg),
        .i_gpio (i_gpio), .i_time (i_time), .i_ack (msg_ack),
        .o_valid (msg_valid), .o_event (msg_event)
    );

    record_arbiter record_arbiter_inst (
        .i_xclk (i_xclk), .i_config_rst (i_config_rst), .i_cfg (cfg),
        .i_gps_valid (gps_valid), .i_gps_event (gps_event),
        .i_msg_valid (msg_valid), .i_msg_event (msg_event),
        .o_gps_ack (gps_ack), .o_msg_ack (msg_ack), .o_rec (o_rec)
    );

endmodule

`default_nettype wire

// File: sim/event_logger_sva.sv
/*
 * protocol assertions on the record arbiter, attached by bind
 * four-word strobe runs, channel code in word 0
 * silence while held, zero word 3 of gps records
 * acknowledge only toward a valid slot
 */
`timescale 1ns/1ps
`default_nettype none
`include "event_logger_macros.svh"

module event_logger_sva (
    input wire                              i_xclk,
    input wire                              i_config_rst,
    input wire event_cfg_pkg::logger_cfg_t  i_cfg,
    input wire                              i_gps_valid,
    input wire                              i_msg_valid,
    input wire                              i_gps_ack,
    input wire                              i_msg_ack,
    input wire event_rec_pkg::rec_word_t    i_rec
);
    import event_rec_pkg::*;

    int unsigned fail_cnt = 0; // failed assertions so far
    logic [3:0]  code;         // top nibble of the current word

    assign code = i_rec.data[`EL_WORD_W-1 -: 4];

    a_run_of_four: assert property (@(posedge i_xclk) disable iff (i_config_rst)
        $rose(i_rec.stb) |-> i_rec.stb ##1 i_rec.stb ##1 i_rec.stb ##1 i_rec.stb ##1 !i_rec.stb)
        else begin
            $error("strobe run is not exactly four words");
            fail_cnt++;
        end

    a_word0_code: assert property (@(posedge i_xclk) disable iff (i_config_rst)
        $rose(i_rec.stb) |-> (code == CHAN_GPS || code == CHAN_MSG))
        else begin
            $error("word 0 carries an unknown channel code");
            fail_cnt++;
        end

    a_quiet_held: assert property (@(posedge i_xclk) disable iff (i_config_rst)
        i_cfg.hold |-> !i_rec.stb)
        else begin
            $error("record strobe while the logger is held");
            fail_cnt++;
        end

    a_gps_word3: assert property (@(posedge i_xclk) disable iff (i_config_rst)
        ($rose(i_rec.stb) && code == CHAN_GPS) |-> ##3 (i_rec.data == '0))
        else begin
            $error("word 3 of a gps record is not zero");
            fail_cnt++;
        end

    a_gps_ack: assert property (@(posedge i_xclk) disable iff (i_config_rst)
        i_gps_ack |-> i_gps_valid)
        else begin
            $error("gps slot acknowledged while empty");
            fail_cnt++;
        end

    a_msg_ack: assert property (@(posedge i_xclk) disable iff (i_config_rst)
        i_msg_ack |-> i_msg_valid)
        else begin
            $error("message slot acknowledged while empty");
            fail_cnt++;
        end

endmodule

bind record_arbiter event_logger_sva event_logger_sva_inst (
    .i_xclk       (i_xclk),
    .i_config_rst (i_config_rst),
    .i_cfg        (i_cfg),
    .i_gps_valid  (i_gps_valid),
    .i_msg_valid  (i_msg_valid),
    .i_gps_ack    (o_gps_ack),
    .i_msg_ack    (o_msg_ack),
    .i_rec        (o_rec)
);

`default_nettype wire

// File: sim/event_logger_tb.sv
/*
 * testbench of the event logger core
 * clock, reset, config writes and gpio pulses
 * expected word queue checked by a monitor with immediate assertions
 * watchdog, per-test lines and closing counts
 */
`timescale 1ns/1ps
`default_nettype none
`include "event_logger_macros.svh"

module event_logger_tb;
    import event_rec_pkg::*;

    localparam logic [3:0] GPS_CODE  = 4'd1;
    localparam logic [3:0] MSG_CODE  = 4'd3;
    localparam int HOLD_CYC   = 400; // pulse length
    localparam int GLITCH_CYC = 150;
    localparam int QUIET_CYC  = 600; // window with no record allowed
    localparam int REC_CYC    = 700; // longest wait for queued words
    localparam int SETTLE_CYC = 300; // filter follows the falling input
    localparam int PULSE_CYC  = HOLD_CYC + REC_CYC + SETTLE_CYC;
    localparam int RUN_CYC    = 6 * PULSE_CYC + HOLD_CYC + GLITCH_CYC + 2 * QUIET_CYC + 1000;

    logic                  xclk;
    logic                  config_rst;
    logic                  cfg_we;
    logic [31:0]           cfg_wd;
    logic [`EL_GPIO_N-1:0] gpio;
    logic [`EL_TIME_W-1:0] time_val;
    rec_word_t             rec;

    logic [`EL_WORD_W-1:0] exp_q[$];  // words still to come
    logic [`EL_WORD_W-1:0] exp_word;
    logic [11:0]           exp_cnt;   // sample counter model
    logic [31:0]           rng = 32'd77980;
    int                    err_cnt = 0;
    int                    err_mark;  // errors before the current test
    int                    chk_cnt = 0;
    int                    test_cnt = 0;

    event_logger_top event_logger_top_inst (
        .i_xclk (xclk), .i_config_rst (config_rst), .i_cfg_we (cfg_we),
        .i_cfg_wd (cfg_wd), .i_gpio (gpio), .i_time (time_val), .o_rec (rec)
    );

    always #10 xclk = ~xclk; // 20 ns

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [31:0] gps_field(input logic [1:0] sel, input logic inv);
        logic [31:0] w;
        w = '0;
        w[`EL_CONF_GPS] = 1'b1;
        w[`EL_CONF_GPS-1 -: 3] = {inv, sel};
        return w;
    endfunction

    function automatic logic [31:0] msg_field(input logic [3:0] idx, input logic inv);
        logic [31:0] w;
        w = '0;
        w[`EL_CONF_MSG] = 1'b1;
        w[`EL_CONF_MSG-1 -: 5] = {inv, idx};
        return w;
    endfunction

    task automatic tick(input int n);
        repeat (n) @(posedge xclk);
        #1; // inputs move 1 ns after the edge
    endtask

    task automatic write_cfg(input logic [31:0] wd);
        cfg_we = 1'b1;
        cfg_wd = wd;
        tick(1);
        cfg_we = 1'b0;
        if (wd[`EL_CONF_EN] && !wd[`EL_CONF_EN-1]) exp_cnt = '0; // hold restarts the count
        tick(4);                                                  // channel clear is over
    endtask

    task automatic expect_record(input logic [3:0] code, input logic [`EL_GPIO_N-1:0] snap);
        exp_q.push_back({code, exp_cnt});
        exp_q.push_back(time_val[15:0]);
        exp_q.push_back(time_val[31:16]);
        exp_q.push_back({{(`EL_WORD_W-`EL_GPIO_N){1'b0}}, snap});
        exp_cnt = exp_cnt + 12'd1;
    endtask

    task automatic wait_drain(input int max_cyc);
        int n;
        n = 0;
        while (exp_q.size() != 0 && n < max_cyc) begin
            tick(1);
            n++;
        end
        if (exp_q.size() != 0) begin
            $display("missing record at %0t ns, %0d expected words never came", $time,
                     exp_q.size());
            err_cnt++;
            exp_q.delete();
        end
    endtask

    // toggle the masked bits, hold, toggle back, wait for the queued records
    task automatic pulse_gpio(input logic [`EL_GPIO_N-1:0] mask, input bit gps, input bit msg);
        if (gps) expect_record(GPS_CODE, '0);
        if (msg) expect_record(MSG_CODE, gpio ^ mask); // snapshot on the active level
        gpio = gpio ^ mask;
        tick(HOLD_CYC);
        gpio = gpio ^ mask;
        wait_drain(REC_CYC);
        tick(SETTLE_CYC);
    endtask

    task automatic start_test();
        rng      = xorshift32(rng);
        time_val = rng; // constant for the whole test
        err_mark = err_cnt;
    endtask

    task automatic finish_test(input string name);
        test_cnt++;
        if (err_cnt == err_mark) $display("test %0d %s: ok", test_cnt, name);
        else $display("test %0d %s: %0d errors", test_cnt, name, err_cnt - err_mark);
    endtask

    always @(negedge xclk) begin // outputs settle between edges
        if (!config_rst && rec.stb) begin
            if (exp_q.size() == 0) begin
                $display("extra record word %h at %0t ns, none was expected", rec.data, $time);
                err_cnt++;
            end else begin
                exp_word = exp_q.pop_front();
                chk_cnt++;
                assert (rec.data == exp_word) else begin
                    $display("error at %0t ns: o_rec.data = %h, expected %h", $time,
                             rec.data, exp_word);
                    err_cnt++;
                end
            end
        end
    end

    initial begin
        repeat (RUN_CYC) @(posedge xclk);
        $display("watchdog expired after %0d cycles, the tests did not finish", RUN_CYC);
        $display("TB FAILED");
        $finish;
    end

    initial begin
        int                    idx;
        logic                  inv;
        logic [`EL_GPIO_N-1:0] bus;
        int unsigned           sva_fails;
        xclk       = 1'b0;
        config_rst = 1'b1;
        cfg_we     = 1'b0;
        cfg_wd     = '0;
        gpio       = '0;
        time_val   = '0;
        exp_cnt    = '0;
        tick(2);                                                // 2 reset cycles
        config_rst = 1'b0;
        write_cfg(32'h0030_0000 | gps_field(2'b01, 1'b0));      // run with gps on pin 3

        start_test();
        pulse_gpio(10'd1 << 3, 1'b1, 1'b0);
        write_cfg(gps_field(2'b01, 1'b1));                      // inverted pin records the fall
        gpio[3] = 1'b1;                                         // rising must stay silent
        tick(HOLD_CYC);
        expect_record(GPS_CODE, '0);
        gpio[3] = 1'b0;
        wait_drain(REC_CYC);
        tick(SETTLE_CYC);
        write_cfg(gps_field(2'b01, 1'b0));
        finish_test("gps pps rising and inverted");

        start_test();
        gpio[3] = 1'b1;
        tick(GLITCH_CYC);
        gpio[3] = 1'b0;
        tick(QUIET_CYC);
        finish_test("short glitch filtered");

        start_test();
        rng = xorshift32(rng);
        idx = rng % `EL_GPIO_N;
        inv = rng[16];
        rng = xorshift32(rng);
        bus = rng[`EL_GPIO_N-1:0];
        bus[idx] = inv;                                         // trigger level starts low
        gpio = bus;                                             // settled before the channel starts
        write_cfg(gps_field(2'b00, 1'b0) | msg_field(idx[3:0], inv));
        pulse_gpio(10'd1 << idx, 1'b0, 1'b1);
        write_cfg(msg_field(4'hf, 1'b0));                       // off before the bus clears
        gpio = '0;
        finish_test("message trigger on random gpio");

        start_test();
        write_cfg(gps_field(2'b01, 1'b0) | msg_field(4'd7, 1'b0));
        pulse_gpio((10'd1 << 3) | (10'd1 << 7), 1'b1, 1'b1);   // same-cycle rise
        finish_test("gps before message");

        start_test();
        write_cfg(32'h0020_0000);                               // run bit 0
        gpio = (10'd1 << 3) | (10'd1 << 7);
        tick(HOLD_CYC);
        gpio = '0;
        tick(QUIET_CYC);
        write_cfg(32'h0030_0000);
        pulse_gpio(10'd1 << 3, 1'b1, 1'b0);                     // counter back at 0
        finish_test("held logger silent");

        start_test();
        write_cfg(~((32'd1 << `EL_CONF_GPS) | (32'd1 << `EL_CONF_MSG) | (32'd1 << `EL_CONF_EN)));
        pulse_gpio(10'd1 << 3, 1'b1, 1'b0);
        finish_test("write without enables");

        sva_fails = event_logger_top_inst.record_arbiter_inst.event_logger_sva_inst.fail_cnt;
        if (sva_fails != 0) begin
            $display("%0d protocol assertions failed on the arbiter", sva_fails);
            err_cnt += sva_fails;
        end
        $display("tests %0d, word checks %0d, errors %0d", test_cnt, chk_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: build.f
+incdir+verilog
verilog/event_cfg_pkg.sv
verilog/event_rec_pkg.sv
verilog/event_cfg_regs.sv
verilog/pulse_denoiser.sv
verilog/event_slot.sv
verilog/gps_pps_channel.sv
verilog/ext_msg_channel.sv
verilog/record_arbiter.sv
verilog/event_logger_top.sv
sim/event_logger_sva.sv
sim/event_logger_tb.sv

// File: Makefile
SIM      := verilator
FLAGS    := --binary --timing --assert -Wno-fatal
TOP      := event_logger_tb
FILELIST := build.f
OBJ_DIR  := obj_dir
SIM_ARGS := +verilator+error+limit+1000
LOG      := sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, and search $(LOG) for the fail message"
	@echo "  clean  remove $(OBJ_DIR) and $(LOG)"
	@echo "  help   this list"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) $(SIM_ARGS) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "TB FAILED" $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q "TB PASSED" $(LOG); then echo "simulation ended without a result"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
